//--- src/lsu_pkg.sv
//**************************************************
// Shared widths, access size encoding and address
// layout for the load/store unit and its testbench
//**************************************************

package lsu_pkg;

   //**************************************************
   // Widths
   //**************************************************
   localparam int DATA_W         = 32;  // Data word width
   localparam int BYTES_PER_WORD = 4;   // Byte lanes per word
   localparam int OFFSET_W       = 12;  // Signed immediate offset
   localparam int MAX_INDEX_BITS = 14;  // Word index field of the address
   localparam int REGION_W       = 16;  // Region field, compared against the DCCM region

   // Same low bits as the RISC-V load/store funct3
   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,
      SZ_HALF = 2'b01,
      SZ_WORD = 2'b10
   } access_size_t;

   //**************************************************
   // Data address word
   //**************************************************
   // Raw view is what the adder produces, field view is what
   // the region check, memory index and lane select look at
   typedef union packed {
      logic [DATA_W-1:0] raw;
      struct packed {
         logic [REGION_W-1:0]       region;      // Bits 31:16
         logic [MAX_INDEX_BITS-1:0] word_index;  // Bits 15:2
         logic [1:0]                byte_off;    // Bits 1:0
      } f;
   } lsu_addr_u;

endpackage : lsu_pkg

//--- src/lsu_mem_if.sv
//**************************************************
// Data memory access bundle between the controller,
// the lane alignment logic and the DCCM array
//**************************************************

interface lsu_mem_if import lsu_pkg::*; ();

   logic                      rden;     // Read strobe, access cycle only
   logic                      wren;     // Write strobe, access cycle only
   logic [MAX_INDEX_BITS-1:0] index;    // Word address
   logic [BYTES_PER_WORD-1:0] byte_en;  // Lane write enables
   logic [DATA_W-1:0]         wdata;    // Lane replicated store data
   logic [DATA_W-1:0]         rdata;    // Full word read back

   modport ctl   (output rden, wren);
   modport align (output index, byte_en, wdata, input rdata);
   modport mem   (input rden, wren, index, byte_en, wdata, output rdata);

endinterface : lsu_mem_if

//--- src/lsu_addr_gen.sv
//**************************************************
// Effective address adder with DCCM region and
// alignment checks, purely combinational
//**************************************************

module lsu_addr_gen import lsu_pkg::*; #(
   parameter logic [REGION_W-1:0] DCCM_REGION     = 16'hF004,
   parameter int                  DCCM_INDEX_BITS = 8
) (
   input  logic [DATA_W-1:0]   rs1,
   input  logic [OFFSET_W-1:0] offset,
   input  access_size_t        size,
   output lsu_addr_u           addr,
   output logic                fault
);

   // Index bits beyond the implemented array, all zero for a full 14 bit DCCM
   localparam logic [MAX_INDEX_BITS-1:0] INDEX_HIGH_MASK =
      ~MAX_INDEX_BITS'((1 << DCCM_INDEX_BITS) - 1);

   logic misaligned;
   logic region_miss;
   logic index_miss;

   assign addr.raw = rs1 + {{(DATA_W-OFFSET_W){offset[OFFSET_W-1]}}, offset};

   always_comb begin
      case (size)
         SZ_HALF: misaligned = addr.f.byte_off[0];
         SZ_WORD: misaligned = |addr.f.byte_off;
         default: misaligned = 1'b0;  // Bytes are always aligned
      endcase
   end

   assign region_miss = (addr.f.region != DCCM_REGION);
   assign index_miss  = |(addr.f.word_index & INDEX_HIGH_MASK);

   assign fault = misaligned | region_miss | index_miss;

endmodule : lsu_addr_gen

//--- src/lsu_align.sv
//**************************************************
// Byte lane steering: store data replication with
// byte enables, load lane extraction with extension
//**************************************************

module lsu_align import lsu_pkg::*; (
   input  lsu_addr_u         addr,
   input  access_size_t      size,
   input  logic              is_unsigned,
   input  logic [DATA_W-1:0] store_data,
   output logic [DATA_W-1:0] load_word,
   lsu_mem_if.align          mem
);

   logic [DATA_W-1:0] rdata_shifted;

   assign mem.index = addr.f.word_index;

   //**************************************************
   // Store path
   //**************************************************
   // Data is copied onto every lane, byte_en picks the live ones
   always_comb begin
      case (size)
         SZ_BYTE: begin
            mem.wdata   = {BYTES_PER_WORD{store_data[7:0]}};
            mem.byte_en = BYTES_PER_WORD'(1) << addr.f.byte_off;
         end
         SZ_HALF: begin
            mem.wdata   = {(DATA_W/16){store_data[15:0]}};
            mem.byte_en = BYTES_PER_WORD'(3) << addr.f.byte_off;  // byte_off is 0 or 2
         end
         default: begin
            mem.wdata   = store_data;
            mem.byte_en = '1;
         end
      endcase
   end

   //**************************************************
   // Load path
   //**************************************************
   assign rdata_shifted = mem.rdata >> {addr.f.byte_off, 3'b000};  // Addressed lane to bit 0

   always_comb begin
      case (size)
         SZ_BYTE: begin
            load_word = {{(DATA_W-8){~is_unsigned & rdata_shifted[7]}},
                         rdata_shifted[7:0]};
         end
         SZ_HALF: begin
            load_word = {{(DATA_W-16){~is_unsigned & rdata_shifted[15]}},
                         rdata_shifted[15:0]};
         end
         default: load_word = rdata_shifted;
      endcase
   end

endmodule : lsu_align

//--- src/lsu_dccm.sv
//**************************************************
// Single-port DCCM array with per-byte write enables,
// read from the registered access address
//**************************************************

module lsu_dccm import lsu_pkg::*; #(
   parameter int DCCM_INDEX_BITS = 8
) (
   input  logic   clk,
   lsu_mem_if.mem mem
);

   localparam int DEPTH = 1 << DCCM_INDEX_BITS;

   logic [DATA_W-1:0]          ram [DEPTH];
   logic [DCCM_INDEX_BITS-1:0] word_addr;

   if (DCCM_INDEX_BITS < 1 || DCCM_INDEX_BITS > MAX_INDEX_BITS) begin : g_bad_depth
      $error("DCCM_INDEX_BITS must be between 1 and MAX_INDEX_BITS");
   end

   // Upper index bits were already range checked by the address unit
   assign word_addr = mem.index[DCCM_INDEX_BITS-1:0];

   // Write lands on the edge that closes the access cycle
   always_ff @(posedge clk) begin
      if (mem.wren) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (mem.byte_en[b]) ram[word_addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
         end
      end
   end

   // Index comes from the captured request, so the word is valid
   // through the access cycle and sampled by the controller at its end
   assign mem.rdata = mem.rden ? ram[word_addr] : '0;

endmodule : lsu_dccm

//--- src/lsu_ctl.sv
//**************************************************
// Request sequencer: four-phase handshake, request
// capture and the single memory access cycle
//**************************************************

module lsu_ctl import lsu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,
   input  logic              is_store,
   input  access_size_t      size,
   input  logic              is_unsigned,
   input  logic [DATA_W-1:0] store_data,
   input  lsu_addr_u         addr,          // From the address adder
   input  logic              fault,
   input  logic [DATA_W-1:0] load_word,     // Extracted and extended read data
   output logic              ack,
   output logic              error,
   output logic [DATA_W-1:0] load_data,
   output lsu_addr_u         addr_q,
   output access_size_t      size_q,
   output logic              is_unsigned_q,
   output logic [DATA_W-1:0] store_data_q,
   lsu_mem_if.ctl            mem
);

   localparam logic [1:0] S_IDLE   = 2'd0;
   localparam logic [1:0] S_ACCESS = 2'd1;
   localparam logic [1:0] S_DONE   = 2'd2;

   logic [1:0] state;
   logic       is_store_q;
   logic       fault_q;
   logic       capture;

   assign capture = (state == S_IDLE) && req;

   //**************************************************
   // Handshake FSM
   //**************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         ack       <= 1'b0;
         error     <= 1'b0;
         load_data <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req) state <= S_ACCESS;
            end
            S_ACCESS: begin
               state <= S_DONE;
               ack   <= 1'b1;
               error <= fault_q;
               if (!is_store_q && !fault_q) load_data <= load_word;
            end
            S_DONE: begin
               // Requester holding req just parks here
               if (!req) begin
                  state <= S_IDLE;
                  ack   <= 1'b0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Request fields, held for the whole transaction
   always_ff @(posedge clk) begin
      if (capture) begin
         addr_q        <= addr;
         fault_q       <= fault;
         is_store_q    <= is_store;
         size_q        <= size;
         is_unsigned_q <= is_unsigned;
         store_data_q  <= store_data;
      end
   end

   // A faulting request spends its access cycle with both strobes low
   assign mem.rden = (state == S_ACCESS) && !fault_q && !is_store_q;
   assign mem.wren = (state == S_ACCESS) && !fault_q && is_store_q;

endmodule : lsu_ctl

//--- src/lsu_top.sv
//**************************************************
// Load/store unit top level with a four-phase req/ack
// request port and a local DCCM
//**************************************************

module lsu_top import lsu_pkg::*; #(
   parameter logic [REGION_W-1:0] DCCM_REGION     = 16'hF004,
   parameter int                  DCCM_INDEX_BITS = 8
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                req,         // Held until ack
   input  logic                is_store,
   input  access_size_t        size,
   input  logic                is_unsigned,
   input  logic [DATA_W-1:0]   rs1,         // Base register
   input  logic [OFFSET_W-1:0] offset,      // Signed immediate
   input  logic [DATA_W-1:0]   store_data,
   output logic                ack,
   output logic                error,       // Misaligned or outside DCCM
   output logic [DATA_W-1:0]   load_data
);

   lsu_addr_u         addr;
   lsu_addr_u         addr_q;
   logic              fault;
   access_size_t      size_q;
   logic              is_unsigned_q;
   logic [DATA_W-1:0] store_data_q;
   logic [DATA_W-1:0] load_word;

   lsu_mem_if mem_if ();

   lsu_addr_gen #(
      .DCCM_REGION     (DCCM_REGION),
      .DCCM_INDEX_BITS (DCCM_INDEX_BITS)
   ) u_addr_gen (
      .rs1    (rs1),
      .offset (offset),
      .size   (size),
      .addr   (addr),
      .fault  (fault)
   );

   lsu_ctl u_ctl (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .is_store      (is_store),
      .size          (size),
      .is_unsigned   (is_unsigned),
      .store_data    (store_data),
      .addr          (addr),
      .fault         (fault),
      .load_word     (load_word),
      .ack           (ack),
      .error         (error),
      .load_data     (load_data),
      .addr_q        (addr_q),
      .size_q        (size_q),
      .is_unsigned_q (is_unsigned_q),
      .store_data_q  (store_data_q),
      .mem           (mem_if.ctl)
   );

   // Lane steering works from the captured request
   lsu_align u_align (
      .addr        (addr_q),
      .size        (size_q),
      .is_unsigned (is_unsigned_q),
      .store_data  (store_data_q),
      .load_word   (load_word),
      .mem         (mem_if.align)
   );

   lsu_dccm #(.DCCM_INDEX_BITS(DCCM_INDEX_BITS)) u_dccm (
      .clk (clk),
      .mem (mem_if.mem)
   );

endmodule : lsu_top

//--- test/lsu_sva.sv
//**************************************************
// Handshake and memory strobe properties, bound into
// the load/store unit top level
//**************************************************

module lsu_sva (
   input logic clk,
   input logic rst_n,
   input logic req,
   input logic ack,
   input logic rden,
   input logic wren
);

   timeunit 1ns;
   timeprecision 1ps;

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> req)
      else $error("ack rose while req was low");

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(rden && wren))
      else $error("rden and wren high together");

   // Release phase bounded to two cycles
   a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(req) |-> ##[0:2] !ack)
      else $error("ack did not fall after req dropped");

endmodule : lsu_sva

bind lsu_top lsu_sva u_sva (
   .clk   (clk),
   .rst_n (rst_n),
   .req   (req),
   .ack   (ack),
   .rden  (mem_if.rden),
   .wren  (mem_if.wren)
);

//--- test/lsu_tb.sv
//**************************************************
// Testbench for the load/store unit: directed table
// then random word traffic against a byte model
//**************************************************

module lsu_tb import lsu_pkg::*; ;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_TABLE  = 19;
   localparam int N_RANDOM = 16;

   typedef struct {
      logic              is_store;
      access_size_t      size;
      logic              is_unsigned;
      logic [DATA_W-1:0] rs1;
      logic [11:0]       offset;
      logic [DATA_W-1:0] store_data;
      logic              exp_error;
      logic [DATA_W-1:0] exp_data;  // Loads only
   } entry_t;

   // DCCM words at 0xF004_0000, region 0xF004
   entry_t tbl [N_TABLE] = '{
      '{1'b1, SZ_WORD, 1'b0, 32'hF004_0010, 12'h000, 32'hA1B2_C3D4, 1'b0, 32'h0},
      '{1'b0, SZ_WORD, 1'b0, 32'hF004_0010, 12'h000, 32'h0, 1'b0, 32'hA1B2_C3D4},
      '{1'b1, SZ_WORD, 1'b0, 32'hF004_0020, 12'h000, 32'h1122_3344, 1'b0, 32'h0},
      '{1'b1, SZ_BYTE, 1'b0, 32'hF004_0020, 12'h001, 32'h0000_00AA, 1'b0, 32'h0},
      '{1'b1, SZ_HALF, 1'b0, 32'hF004_0020, 12'h002, 32'h0000_BEEF, 1'b0, 32'h0},
      '{1'b0, SZ_WORD, 1'b0, 32'hF004_0020, 12'h000, 32'h0, 1'b0, 32'hBEEF_AA44},
      '{1'b0, SZ_BYTE, 1'b0, 32'hF004_0021, 12'h000, 32'h0, 1'b0, 32'hFFFF_FFAA},
      '{1'b0, SZ_BYTE, 1'b1, 32'hF004_0021, 12'h000, 32'h0, 1'b0, 32'h0000_00AA},
      '{1'b0, SZ_HALF, 1'b0, 32'hF004_0022, 12'h000, 32'h0, 1'b0, 32'hFFFF_BEEF},
      '{1'b0, SZ_HALF, 1'b1, 32'hF004_0022, 12'h000, 32'h0, 1'b0, 32'h0000_BEEF},
      '{1'b0, SZ_BYTE, 1'b0, 32'hF004_0020, 12'h000, 32'h0, 1'b0, 32'h0000_0044},
      '{1'b1, SZ_WORD, 1'b0, 32'hF004_0110, 12'hFF0, 32'h5A5A_0F0F, 1'b0, 32'h0},  // -16
      '{1'b0, SZ_WORD, 1'b0, 32'hF004_00F0, 12'h010, 32'h0, 1'b0, 32'h5A5A_0F0F},
      '{1'b0, SZ_HALF, 1'b0, 32'hF004_0021, 12'h000, 32'h0, 1'b1, 32'h0},
      '{1'b0, SZ_WORD, 1'b0, 32'hF004_0022, 12'h000, 32'h0, 1'b1, 32'h0},
      '{1'b1, SZ_WORD, 1'b0, 32'hF005_0010, 12'h000, 32'h0BAD_0001, 1'b1, 32'h0},
      '{1'b1, SZ_WORD, 1'b0, 32'hF004_0410, 12'h000, 32'h0BAD_0002, 1'b1, 32'h0},  // Index 260
      '{1'b1, SZ_WORD, 1'b0, 32'hF004_0012, 12'h000, 32'hDEAD_BEEF, 1'b1, 32'h0},
      '{1'b0, SZ_WORD, 1'b0, 32'hF004_0010, 12'h000, 32'h0, 1'b0, 32'hA1B2_C3D4}
   };

   logic              clk;
   logic              rst_n;
   logic              req;
   logic              is_store;
   access_size_t      size;
   logic              is_unsigned;
   logic [DATA_W-1:0] rs1;
   logic [OFFSET_W-1:0] offset;
   logic [DATA_W-1:0] store_data;
   logic              ack;
   logic              error;
   logic [DATA_W-1:0] load_data;

   logic [7:0] ref_mem [1024];  // Byte model of the 256 word DCCM
   bit         written [256];
   int         seed;
   int         n_tests;
   int         n_fail;
   bit         test_ok;

   lsu_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         test_ok = 1'b0;
      end
   endtask

   task automatic finish_test(input string tag);
      n_tests++;
      if (test_ok) $display("%s: pass", tag);
      else begin
         n_fail++;
         $display("%s: FAIL", tag);
      end
   endtask

   //**************************************************
   // One full four-phase transaction
   //**************************************************
   task automatic run_request(input entry_t e, input string tag);
      test_ok = 1'b1;
      @(posedge clk);
      req         <= 1'b1;
      is_store    <= e.is_store;
      size        <= e.size;
      is_unsigned <= e.is_unsigned;
      rs1         <= e.rs1;
      offset      <= e.offset;
      store_data  <= e.store_data;
      @(negedge clk);
      while (ack !== 1'b1) @(negedge clk);
      compare("error", 32'(error), 32'(e.exp_error));
      if (!e.is_store && !e.exp_error) compare("load_data", load_data, e.exp_data);
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      compare("ack", 32'(ack), 32'h1);  // Still held, req not yet seen low
      while (ack !== 1'b0) @(negedge clk);  // Release phase
      finish_test(tag);
   endtask

   // Eight aligned words in the upper half of the DCCM, away from the table
   // addresses, so that words are revisited and read back
   task automatic run_random();
      entry_t            e;
      int                r;
      int                widx;
      logic [DATA_W-1:0] addr;
      logic [11:0]       off;
      for (int i = 0; i < N_RANDOM; i++) begin
         r    = $random(seed);
         widx = 128 + (r & 7);
         addr = 32'hF004_0000 | 32'(widx << 2);
         off  = 12'($random(seed)) & 12'hFFC;
         e.is_store    = r[8] | !written[widx];  // First touch is always a store
         e.size        = SZ_WORD;
         e.is_unsigned = 1'b0;
         e.offset      = off;
         e.rs1         = addr - {{20{off[11]}}, off};
         e.store_data  = $random(seed);
         e.exp_error   = 1'b0;
         e.exp_data    = '0;
         if (e.is_store) begin
            for (int b = 0; b < 4; b++) ref_mem[widx*4 + b] = e.store_data[b*8 +: 8];
            written[widx] = 1'b1;
         end else begin
            e.exp_data = {ref_mem[widx*4 + 3], ref_mem[widx*4 + 2],
                          ref_mem[widx*4 + 1], ref_mem[widx*4]};
         end
         run_request(e, $sformatf("Random %0d", i));
      end
   endtask

   initial begin
      seed        = 563;
      rst_n       = 1'b0;
      req         = 1'b0;
      is_store    = 1'b0;
      size        = SZ_WORD;
      is_unsigned = 1'b0;
      rs1         = '0;
      offset      = '0;
      store_data  = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      test_ok = 1'b1;
      compare("ack", 32'(ack), 32'h0);
      compare("error", 32'(error), 32'h0);
      compare("load_data", load_data, 32'h0);
      finish_test("Reset");
      for (int i = 0; i < N_TABLE; i++) run_request(tbl[i], $sformatf("Table %0d", i));
      run_random();
      $display("Tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
      if (n_fail == 0) $display("Test completed successfully");
      else $display("Test failed");
      $finish;
   end

   // Watchdog, 20 cycles per request plus reset
   initial begin
      repeat ((N_TABLE + N_RANDOM) * 20 + 4) @(posedge clk);
      $display("Timeout: a request did not finish its handshake in time");
      $display("Test failed");
      $finish;
   end

endmodule : lsu_tb

//--- src.f
src/lsu_pkg.sv
src/lsu_mem_if.sv
src/lsu_addr_gen.sv
src/lsu_align.sv
src/lsu_dccm.sv
src/lsu_ctl.sv
src/lsu_top.sv
test/lsu_sva.sv
test/lsu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = lsu_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
